/* issue_config.svh */
`ifndef ISSUE_CONFIG_SVH
`define ISSUE_CONFIG_SVH

// data word width
`define XLEN 32

// reorder buffer entries
`define ROB_DEPTH 8

// rob tag width, tag 0 means value present
`define TAG_W 3

// architectural register index width
`define REG_W 5

`endif

/* issue_pkg.sv */
`include "issue_config.svh"

package issue_pkg;

    // five views of one rv32i instruction word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // branch offset bits are scattered
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
    } instr_word_u;

    typedef enum logic [6:0] {
        op_auipc = 7'b0010111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_e;

    // low three bits follow funct3, msb marks sub
    typedef enum logic [3:0] {
        alu_add = 4'b0000,
        alu_sll = 4'b0001,
        alu_xor = 4'b0100,
        alu_or  = 4'b0110,
        alu_and = 4'b0111,
        alu_sub = 4'b1000
    } alu_op_e;

    typedef enum logic [1:0] {
        unit_none,
        unit_alu,
        unit_cmp,
        unit_lsb
    } unit_e;

    typedef struct packed {
        instr_word_u       instr;
        logic [`XLEN-1:0]  pc;
    } iq_entry_t;

    typedef struct packed {
        unit_e             unit;
        alu_op_e           alu_op;
        logic [2:0]        funct3;
        logic [`XLEN-1:0]  imm;
        logic [`XLEN-1:0]  pc;
        logic [`REG_W-1:0] rs1;
        logic [`REG_W-1:0] rs2;
        logic [`REG_W-1:0] rd;
        // vj taken from pc
        logic              vj_pc;
        // vk taken from imm
        logic              vk_imm;
        // rd renamed to the new rob tag
        logic              rd_tag;
    } decoded_op_t;

    typedef struct packed {
        logic [`XLEN-1:0]  vj;
        logic [`TAG_W-1:0] qj;
        logic [`XLEN-1:0]  vk;
        logic [`TAG_W-1:0] qk;
    } regfile_read_t;

    typedef struct packed {
        logic             ready;
        logic [`XLEN-1:0] value;
    } rob_entry_t;

    typedef rob_entry_t [`ROB_DEPTH-1:0] rob_view_t;

    typedef struct packed {
        logic              valid;
        alu_op_e           alu_op;
        logic [`XLEN-1:0]  vj;
        logic [`XLEN-1:0]  vk;
        logic [`TAG_W-1:0] qj;
        logic [`TAG_W-1:0] qk;
        logic [`TAG_W-1:0] tag;
    } alu_issue_t;

    typedef struct packed {
        logic              valid;
        logic [2:0]        funct3;
        logic [`XLEN-1:0]  vj;
        logic [`XLEN-1:0]  vk;
        logic [`TAG_W-1:0] qj;
        logic [`TAG_W-1:0] qk;
        logic [`TAG_W-1:0] tag;
    } cmp_issue_t;

    typedef struct packed {
        logic              valid;
        logic              is_store;
        logic [2:0]        funct3;
        logic [`XLEN-1:0]  vj;
        logic [`XLEN-1:0]  vk;
        logic [`TAG_W-1:0] qj;
        logic [`TAG_W-1:0] qk;
        logic [`XLEN-1:0]  offset;
        logic [`TAG_W-1:0] tag;
    } lsb_issue_t;

endpackage

/* instr_decoder.sv */
`timescale 1ns/100ps
`include "issue_config.svh"

module instr_decoder import issue_pkg::*; (
    input  iq_entry_t   iq_entry_i,
    output decoded_op_t dec_op_o
);

    instr_word_u      iw;
    logic [`XLEN-1:0] i_imm;
    logic [`XLEN-1:0] s_imm;
    logic [`XLEN-1:0] b_imm;
    logic [`XLEN-1:0] u_imm;
    logic             alu_f3_ok;
    logic             ld_f3_ok;
    logic             st_f3_ok;
    logic             br_f3_ok;
    logic             is_sub;

    assign iw = iq_entry_i.instr;

    // sign-extended immediates, one per format view
    assign i_imm = {{(`XLEN-12){iw.i.imm[11]}}, iw.i.imm};
    assign s_imm = {{(`XLEN-12){iw.s.imm_hi[6]}}, iw.s.imm_hi, iw.s.imm_lo};
    assign b_imm = {{(`XLEN-12){iw.b.imm12}}, iw.b.imm11, iw.b.imm10_5, iw.b.imm4_1, 1'b0};
    assign u_imm = {iw.u.imm, 12'h000};

    // kept alu funct3: add/sub, sll, xor, or, and
    always_comb begin
        case (iw.r.funct3)
            3'b000, 3'b001, 3'b100, 3'b110, 3'b111: alu_f3_ok = 1'b1;
            default:                                alu_f3_ok = 1'b0;
        endcase
    end

    // lb lh lw lbu lhu
    assign ld_f3_ok = (iw.r.funct3 != 3'b011) && (iw.r.funct3[2:1] != 2'b11);
    // sb sh sw
    assign st_f3_ok = (iw.r.funct3 <= 3'b010);
    // 010 and 011 are not branches
    assign br_f3_ok = (iw.r.funct3[2:1] != 2'b01);
    // funct7 bit 5 only means sub on the add slot
    assign is_sub   = iw.r.funct7[5] && (iw.r.funct3 == 3'b000);

    always_comb begin
        dec_op_o        = '0;
        dec_op_o.unit   = unit_none;
        dec_op_o.alu_op = alu_add;
        dec_op_o.funct3 = iw.r.funct3;
        dec_op_o.pc     = iq_entry_i.pc;
        dec_op_o.rs1    = iw.r.rs1;
        dec_op_o.rs2    = iw.r.rs2;
        dec_op_o.rd     = iw.r.rd;
        case (opcode_e'(iw.r.opcode))
            op_auipc: begin
                // pc + upper immediate on the alu
                dec_op_o.unit   = unit_alu;
                dec_op_o.imm    = u_imm;
                dec_op_o.vj_pc  = 1'b1;
                dec_op_o.vk_imm = 1'b1;
                dec_op_o.rd_tag = 1'b1;
            end
            op_br: begin
                if (br_f3_ok)
                    dec_op_o.unit = unit_cmp;
                dec_op_o.imm = b_imm;
            end
            op_load: begin
                if (ld_f3_ok)
                    dec_op_o.unit = unit_lsb;
                dec_op_o.imm    = i_imm;
                dec_op_o.rd_tag = 1'b1;
            end
            op_store: begin
                // rd field holds offset bits here
                if (st_f3_ok)
                    dec_op_o.unit = unit_lsb;
                dec_op_o.imm = s_imm;
            end
            op_imm: begin
                if (alu_f3_ok)
                    dec_op_o.unit = unit_alu;
                dec_op_o.alu_op = alu_op_e'({1'b0, iw.i.funct3});
                dec_op_o.imm    = i_imm;
                dec_op_o.vk_imm = 1'b1;
                dec_op_o.rd_tag = 1'b1;
            end
            op_reg: begin
                if (alu_f3_ok)
                    dec_op_o.unit = unit_alu;
                dec_op_o.alu_op = alu_op_e'({is_sub, iw.r.funct3});
                dec_op_o.rd_tag = 1'b1;
            end
            default: ;
        endcase
        // result to x0 is thrown away, nothing to issue
        if (dec_op_o.rd_tag && dec_op_o.rd == '0)
            dec_op_o.unit = unit_none;
        if (dec_op_o.unit == unit_none)
            dec_op_o.rd_tag = 1'b0;
    end

endmodule

/* issue_slot.sv */
`timescale 1ns/100ps

module issue_slot import issue_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        iq_valid_i,
    input  decoded_op_t dec_op_i,
    input  logic        issue_now_i,
    output logic        iq_read_o,
    output logic        slot_valid_o,
    output decoded_op_t slot_op_o
);

    // take a new entry when empty or when the held one leaves this cycle
    assign iq_read_o = iq_valid_i && (!slot_valid_o || issue_now_i);

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_valid_o <= 1'b0;
        end else if (iq_read_o) begin
            slot_valid_o <= 1'b1;
        end else if (issue_now_i) begin
            // issued with nothing behind it
            slot_valid_o <= 1'b0;
        end
    end

    // held stable through stalls
    always_ff @(posedge clk) begin
        if (iq_read_o) begin
            slot_op_o <= dec_op_i;
        end
    end

endmodule

/* dispatch_unit.sv */
`timescale 1ns/100ps
`include "issue_config.svh"

module dispatch_unit import issue_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              slot_valid_i,
    input  decoded_op_t       slot_op_i,
    input  regfile_read_t     regfile_i,
    input  rob_view_t         rob_i,
    input  logic [`TAG_W-1:0] rob_free_tag_i,
    input  logic              alu_full_i,
    input  logic              cmp_full_i,
    input  logic              lsb_full_i,
    output logic              issue_now_o,
    output logic [`REG_W-1:0] rs1_o,
    output logic [`REG_W-1:0] rs2_o,
    output logic [`REG_W-1:0] rd_o,
    output logic              load_tag_o,
    output logic [`TAG_W-1:0] tag_o,
    output logic              rob_write_o,
    output logic [`REG_W-1:0] rob_dest_o,
    output alu_issue_t        alu_o,
    output cmp_issue_t        cmp_o,
    output lsb_issue_t        lsb_o
);

    logic              hit_j;
    logic              hit_k;
    logic [`XLEN-1:0]  vj;
    logic [`XLEN-1:0]  vk;
    logic [`TAG_W-1:0] qj;
    logic [`TAG_W-1:0] qk;
    logic              unit_full;
    logic              to_unit;
    logic              send;
    logic              is_store;

    // pending tag whose rob entry already finished
    function automatic logic rob_hit(input logic [`TAG_W-1:0] q, input rob_view_t rob);
        return (q != '0) && rob[q].ready;
    endfunction

    // register file is read with the held instruction
    assign rs1_o = slot_op_i.rs1;
    assign rs2_o = slot_op_i.rs2;

    assign hit_j = rob_hit(regfile_i.qj, rob_i);
    assign hit_k = rob_hit(regfile_i.qk, rob_i);

    // rob bypass, then pc / immediate override
    always_comb begin
        vj = hit_j ? rob_i[regfile_i.qj].value : regfile_i.vj;
        qj = hit_j ? '0 : regfile_i.qj;
        vk = hit_k ? rob_i[regfile_i.qk].value : regfile_i.vk;
        qk = hit_k ? '0 : regfile_i.qk;
        if (slot_op_i.vj_pc) begin
            vj = slot_op_i.pc;
            qj = '0;
        end
        if (slot_op_i.vk_imm) begin
            vk = slot_op_i.imm;
            qk = '0;
        end
    end

    always_comb begin
        case (slot_op_i.unit)
            unit_alu: unit_full = alu_full_i;
            unit_cmp: unit_full = cmp_full_i;
            unit_lsb: unit_full = lsb_full_i;
            default:  unit_full = 1'b0;
        endcase
    end

    // single issue decision, shared by the station and tag paths
    assign to_unit     = (slot_op_i.unit != unit_none);
    assign issue_now_o = slot_valid_i && (!to_unit || (rob_free_tag_i != '0 && !unit_full));
    assign send        = issue_now_o && to_unit;

    // rename rd in the register file at this edge
    assign load_tag_o = send && slot_op_i.rd_tag;
    assign rd_o       = slot_op_i.rd;
    assign tag_o      = rob_free_tag_i;

    // the only lsb op without a destination
    assign is_store = (slot_op_i.unit == unit_lsb) && !slot_op_i.rd_tag;

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_o.valid <= 1'b0;
            cmp_o.valid <= 1'b0;
            lsb_o.valid <= 1'b0;
            rob_write_o <= 1'b0;
        end else begin
            alu_o.valid <= send && (slot_op_i.unit == unit_alu);
            cmp_o.valid <= send && (slot_op_i.unit == unit_cmp);
            lsb_o.valid <= send && (slot_op_i.unit == unit_lsb);
            rob_write_o <= send;
            // payload is shared, valid picks the station
            if (send) begin
                alu_o.alu_op   <= slot_op_i.alu_op;
                alu_o.vj       <= vj;
                alu_o.vk       <= vk;
                alu_o.qj       <= qj;
                alu_o.qk       <= qk;
                alu_o.tag      <= rob_free_tag_i;
                cmp_o.funct3   <= slot_op_i.funct3;
                cmp_o.vj       <= vj;
                cmp_o.vk       <= vk;
                cmp_o.qj       <= qj;
                cmp_o.qk       <= qk;
                cmp_o.tag      <= rob_free_tag_i;
                lsb_o.is_store <= is_store;
                lsb_o.funct3   <= slot_op_i.funct3;
                lsb_o.vj       <= vj;
                // load has no data operand, rs2 bits are offset
                lsb_o.vk       <= is_store ? vk : '0;
                lsb_o.qk       <= is_store ? qk : '0;
                lsb_o.qj       <= qj;
                lsb_o.offset   <= slot_op_i.imm;
                lsb_o.tag      <= rob_free_tag_i;
                // stores and branches write no register
                rob_dest_o     <= slot_op_i.rd_tag ? slot_op_i.rd : '0;
            end
        end
    end

endmodule

/* issue_stage.sv */
`timescale 1ns/100ps
`include "issue_config.svh"

module issue_stage import issue_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    // instruction queue
    input  logic              iq_valid_i,
    input  iq_entry_t         iq_entry_i,
    output logic              iq_read_o,
    // register file
    output logic [`REG_W-1:0] rs1_o,
    output logic [`REG_W-1:0] rs2_o,
    input  regfile_read_t     regfile_i,
    output logic              load_tag_o,
    output logic [`REG_W-1:0] rd_o,
    output logic [`TAG_W-1:0] tag_o,
    // reorder buffer
    input  logic [`TAG_W-1:0] rob_free_tag_i,
    input  rob_view_t         rob_i,
    output logic              rob_write_o,
    output logic [`REG_W-1:0] rob_dest_o,
    // stations
    input  logic              alu_full_i,
    input  logic              cmp_full_i,
    input  logic              lsb_full_i,
    output alu_issue_t        alu_o,
    output cmp_issue_t        cmp_o,
    output lsb_issue_t        lsb_o
);

    decoded_op_t dec_op;
    decoded_op_t slot_op;
    logic        slot_valid;
    logic        issue_now;

    instr_decoder i_decoder (
        .iq_entry_i (iq_entry_i),
        .dec_op_o   (dec_op)
    );

    // one held instruction between decode and issue
    issue_slot i_slot (
        .clk          (clk),
        .rst          (rst),
        .iq_valid_i   (iq_valid_i),
        .dec_op_i     (dec_op),
        .issue_now_i  (issue_now),
        .iq_read_o    (iq_read_o),
        .slot_valid_o (slot_valid),
        .slot_op_o    (slot_op)
    );

    dispatch_unit i_dispatch (
        .clk            (clk),
        .rst            (rst),
        .slot_valid_i   (slot_valid),
        .slot_op_i      (slot_op),
        .regfile_i      (regfile_i),
        .rob_i          (rob_i),
        .rob_free_tag_i (rob_free_tag_i),
        .alu_full_i     (alu_full_i),
        .cmp_full_i     (cmp_full_i),
        .lsb_full_i     (lsb_full_i),
        .issue_now_o    (issue_now),
        .rs1_o          (rs1_o),
        .rs2_o          (rs2_o),
        .rd_o           (rd_o),
        .load_tag_o     (load_tag_o),
        .tag_o          (tag_o),
        .rob_write_o    (rob_write_o),
        .rob_dest_o     (rob_dest_o),
        .alu_o          (alu_o),
        .cmp_o          (cmp_o),
        .lsb_o          (lsb_o)
    );

endmodule

/* issue_assert.sv */
`timescale 1ns/100ps

module issue_assert (
    input logic clk,
    input logic rst,
    input logic alu_valid_i,
    input logic cmp_valid_i,
    input logic lsb_valid_i,
    input logic rob_write_i
);

    logic any_valid;

    assign any_valid = alu_valid_i || cmp_valid_i || lsb_valid_i;

    // one station per issued instruction
    one_station: assert property (@(posedge clk) disable iff (rst)
        $onehot0({alu_valid_i, cmp_valid_i, lsb_valid_i}))
        else $error("more than one station valid in the same cycle");

    // every station issue also allocates a rob entry
    rob_follows: assert property (@(posedge clk) disable iff (rst)
        any_valid |-> rob_write_i)
        else $error("station valid without rob_write_o");

    // valids are cleared by the first reset edge
    quiet_in_reset: assert property (@(posedge clk)
        rst && $past(rst) |-> !any_valid && !rob_write_i)
        else $error("valid output high during reset");

endmodule

bind dispatch_unit issue_assert i_issue_assert (
    .clk         (clk),
    .rst         (rst),
    .alu_valid_i (alu_o.valid),
    .cmp_valid_i (cmp_o.valid),
    .lsb_valid_i (lsb_o.valid),
    .rob_write_i (rob_write_o)
);

/* tb_issue_stage.sv */
`timescale 1ns/100ps
`include "issue_config.svh"

module tb_issue_stage import issue_pkg::*; ();

    localparam int MAX_LINES       = 64;
    localparam int RESET_CYCLES    = 5;
    localparam int CYCLES_PER_LINE = 40;

    logic              clk;
    logic              rst;
    logic              iq_valid;
    iq_entry_t         iq_entry;
    logic              iq_read;
    logic [`REG_W-1:0] rs1;
    logic [`REG_W-1:0] rs2;
    regfile_read_t     regfile;
    logic              load_tag;
    logic [`REG_W-1:0] rd;
    logic [`TAG_W-1:0] tag;
    logic [`TAG_W-1:0] rob_free_tag;
    rob_view_t         rob;
    logic              rob_write;
    logic [`REG_W-1:0] rob_dest;
    logic              alu_full;
    logic              cmp_full;
    logic              lsb_full;
    alu_issue_t        alu_out;
    cmp_issue_t        cmp_out;
    lsb_issue_t        lsb_out;

    // stimulus columns with one entry per line
    logic [31:0] s_instr [MAX_LINES];
    logic [31:0] s_pc    [MAX_LINES];
    logic [31:0] s_full  [MAX_LINES];
    logic [31:0] s_notag [MAX_LINES];
    logic [31:0] s_hold  [MAX_LINES];
    logic [31:0] s_tag   [MAX_LINES];
    logic [31:0] s_unit  [MAX_LINES];
    logic [31:0] s_op    [MAX_LINES];
    logic [31:0] s_ksrc  [MAX_LINES];
    logic [31:0] s_vk    [MAX_LINES];
    logic [31:0] s_off   [MAX_LINES];
    int          n_lines;

    // register file tags and rob ready bits
    logic [`TAG_W-1:0]     rf_tag [2**`REG_W];
    logic [`ROB_DEPTH-1:0] ready_mask;
    logic [31:0]           seed;

    // expected station payload one cycle behind the issue
    logic        pend;
    int          pend_line;
    logic [31:0] pend_vj;
    logic [31:0] pend_vk;
    logic [31:0] pend_qj;
    logic [31:0] pend_qk;

    issue_stage i_issue_stage (
        .clk            (clk),
        .rst            (rst),
        .iq_valid_i     (iq_valid),
        .iq_entry_i     (iq_entry),
        .iq_read_o      (iq_read),
        .rs1_o          (rs1),
        .rs2_o          (rs2),
        .regfile_i      (regfile),
        .load_tag_o     (load_tag),
        .rd_o           (rd),
        .tag_o          (tag),
        .rob_free_tag_i (rob_free_tag),
        .rob_i          (rob),
        .rob_write_o    (rob_write),
        .rob_dest_o     (rob_dest),
        .alu_full_i     (alu_full),
        .cmp_full_i     (cmp_full),
        .lsb_full_i     (lsb_full),
        .alu_o          (alu_out),
        .cmp_o          (cmp_out),
        .lsb_o          (lsb_out)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] reg_value(input logic [`REG_W-1:0] r);
        return 32'(r) * 32'h101;
    endfunction

    // xorshift32
    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // alu ops and loads rename rd but stores and branches do not
    function automatic logic claims_rd(input int k);
        return s_unit[k] == 1 || (s_unit[k] == 3 && s_instr[k][6:0] != 7'h23);
    endfunction

    // register file answers combinationally
    always_comb begin
        regfile.vj = reg_value(rs1);
        regfile.qj = rf_tag[rs1];
        regfile.vk = reg_value(rs2);
        regfile.qk = rf_tag[rs2];
    end

    always_comb begin
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            rob[i].ready = ready_mask[i];
            rob[i].value = 32'hA000 + 32'(i);
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("error %s got %h expected %h", name, got, expected);
            $display("TESTS FAILED");
            $fatal(1, "check on %s failed", name);
        end
    endtask

    task automatic read_stimulus();
        int    fd;
        int    cnt;
        int    status;
        string line;
        fd = $fopen("issue_stimulus.txt", "r");
        if (fd == 0) begin
            $display("TESTS FAILED");
            $fatal(1, "could not open the stimulus file");
        end
        while (!$feof(fd) && n_lines < MAX_LINES) begin
            line = "";
            status = $fgets(line, fd);
            // skip blank and comment lines
            if (status > 0 && line.len() > 1 && line.getc(0) != "#") begin
                cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                              s_instr[n_lines], s_pc[n_lines], s_full[n_lines],
                              s_notag[n_lines], s_hold[n_lines], s_tag[n_lines],
                              s_unit[n_lines], s_op[n_lines], s_ksrc[n_lines],
                              s_vk[n_lines], s_off[n_lines]);
                if (cnt != 11) begin
                    $display("TESTS FAILED");
                    $fatal(1, "stimulus line %0d has a missing column", n_lines + 1);
                end
                n_lines++;
            end
        end
        $fclose(fd);
        if (n_lines == 0) begin
            $display("TESTS FAILED");
            $fatal(1, "the stimulus file holds no instructions");
        end
    endtask

    // bypass rule applied to the two models
    task automatic read_operand(input logic [`REG_W-1:0] r, output logic [31:0] v,
                                output logic [31:0] q);
        logic [`TAG_W-1:0] t;
        t = rf_tag[r];
        if (t != '0 && ready_mask[t]) begin
            v = 32'hA000 + 32'(t);
            q = '0;
        end else begin
            v = reg_value(r);
            q = 32'(t);
        end
    endtask

    task automatic predict_operands(input int k);
        // auipc adds to its own pc
        if (s_instr[k][6:0] == 7'h17) begin
            pend_vj = s_pc[k];
            pend_qj = '0;
        end else begin
            read_operand(s_instr[k][19:15], pend_vj, pend_qj);
        end
        if (s_ksrc[k] != 0) begin
            read_operand(s_instr[k][24:20], pend_vk, pend_qk);
        end else begin
            pend_vk = s_vk[k];
            pend_qk = '0;
        end
    endtask

    // station outputs registered from the previous issue
    task automatic check_outputs();
        int unit;
        int k;
        k = pend_line;
        unit = pend ? int'(s_unit[k]) : 0;
        check_value("alu_o.valid", 32'(alu_out.valid), 32'(pend && unit == 1));
        check_value("cmp_o.valid", 32'(cmp_out.valid), 32'(pend && unit == 2));
        check_value("lsb_o.valid", 32'(lsb_out.valid), 32'(pend && unit == 3));
        check_value("rob_write_o", 32'(rob_write), 32'(pend));
        if (pend) begin
            check_value("rob_dest_o", 32'(rob_dest),
                        claims_rd(k) ? 32'(s_instr[k][11:7]) : 32'h0);
            case (unit)
                1: begin
                    check_value("alu_o.alu_op", 32'(alu_out.alu_op), s_op[k]);
                    check_value("alu_o.vj", alu_out.vj, pend_vj);
                    check_value("alu_o.vk", alu_out.vk, pend_vk);
                    check_value("alu_o.qj", 32'(alu_out.qj), pend_qj);
                    check_value("alu_o.qk", 32'(alu_out.qk), pend_qk);
                    check_value("alu_o.tag", 32'(alu_out.tag), s_tag[k]);
                end
                2: begin
                    check_value("cmp_o.funct3", 32'(cmp_out.funct3), s_op[k]);
                    check_value("cmp_o.vj", cmp_out.vj, pend_vj);
                    check_value("cmp_o.vk", cmp_out.vk, pend_vk);
                    check_value("cmp_o.qj", 32'(cmp_out.qj), pend_qj);
                    check_value("cmp_o.qk", 32'(cmp_out.qk), pend_qk);
                    check_value("cmp_o.tag", 32'(cmp_out.tag), s_tag[k]);
                end
                default: begin
                    check_value("lsb_o.is_store", 32'(lsb_out.is_store),
                                32'(s_instr[k][6:0] == 7'h23));
                    check_value("lsb_o.funct3", 32'(lsb_out.funct3), s_op[k]);
                    check_value("lsb_o.vj", lsb_out.vj, pend_vj);
                    check_value("lsb_o.vk", lsb_out.vk, pend_vk);
                    check_value("lsb_o.qj", 32'(lsb_out.qj), pend_qj);
                    check_value("lsb_o.qk", 32'(lsb_out.qk), pend_qk);
                    check_value("lsb_o.offset", lsb_out.offset, s_off[k]);
                    check_value("lsb_o.tag", 32'(lsb_out.tag), s_tag[k]);
                end
            endcase
        end
    endtask

    initial begin
        int   q_line;
        int   slot_line;
        int   hold_left;
        int   unit;
        logic unit_full;
        logic exp_issue;
        logic exp_send;
        logic exp_claim;
        logic exp_read;
        logic smp_read;
        logic smp_issue;
        logic smp_claim;
        logic done;
        rst          = 1'b1;
        iq_valid     = 1'b0;
        iq_entry     = '0;
        rob_free_tag = '0;
        alu_full     = 1'b0;
        cmp_full     = 1'b0;
        lsb_full     = 1'b0;
        ready_mask   = '0;
        seed         = 32'h6cc4b185;
        n_lines      = 0;
        pend         = 1'b0;
        pend_line    = 0;
        for (int r = 0; r < 2**`REG_W; r++) begin
            rf_tag[r] = '0;
        end
        read_stimulus();
        q_line    = 0;
        slot_line = -1;
        hold_left = 0;
        smp_read  = 1'b0;
        smp_issue = 1'b0;
        smp_claim = 1'b0;
        done      = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        while (!done) begin
            // models follow the edge that just passed
            if (smp_claim) begin
                rf_tag[s_instr[slot_line][11:7]] = s_tag[slot_line][`TAG_W-1:0];
            end
            if (smp_read) begin
                slot_line = q_line;
                hold_left = int'(s_hold[q_line]);
                q_line++;
            end else if (smp_issue) begin
                slot_line = -1;
            end else if (slot_line >= 0 && hold_left > 0) begin
                hold_left--;
            end
            seed       = next_random(seed);
            ready_mask = seed[`ROB_DEPTH-1:0];
            if (q_line < n_lines) begin
                iq_valid = 1'b1;
                iq_entry = {s_instr[q_line], s_pc[q_line]};
            end else begin
                iq_valid = 1'b0;
                iq_entry = '0;
            end
            // back-pressure for the held instruction while its hold lasts
            if (slot_line >= 0 && hold_left > 0) begin
                alu_full     = s_full[slot_line][0];
                cmp_full     = s_full[slot_line][1];
                lsb_full     = s_full[slot_line][2];
                rob_free_tag = s_notag[slot_line][0] ? '0 : s_tag[slot_line][`TAG_W-1:0];
            end else begin
                alu_full     = 1'b0;
                cmp_full     = 1'b0;
                lsb_full     = 1'b0;
                rob_free_tag = (slot_line >= 0) ? s_tag[slot_line][`TAG_W-1:0] : `TAG_W'(1);
            end
            @(negedge clk);
            check_outputs();
            exp_issue = 1'b0;
            exp_send  = 1'b0;
            exp_claim = 1'b0;
            if (slot_line >= 0) begin
                // register file read ports follow the held instruction
                check_value("rs1_o", 32'(rs1), 32'(s_instr[slot_line][19:15]));
                check_value("rs2_o", 32'(rs2), 32'(s_instr[slot_line][24:20]));
                unit = int'(s_unit[slot_line]);
                case (unit)
                    1:       unit_full = alu_full;
                    2:       unit_full = cmp_full;
                    3:       unit_full = lsb_full;
                    default: unit_full = 1'b0;
                endcase
                exp_issue = unit == 0 || (rob_free_tag != '0 && !unit_full);
                exp_send  = exp_issue && unit != 0;
                exp_claim = exp_send && claims_rd(slot_line);
            end
            exp_read = iq_valid && (slot_line < 0 || exp_issue);
            check_value("iq_read_o", 32'(iq_read), 32'(exp_read));
            check_value("load_tag_o", 32'(load_tag), 32'(exp_claim));
            if (exp_claim) begin
                check_value("rd_o", 32'(rd), 32'(s_instr[slot_line][11:7]));
                check_value("tag_o", 32'(tag), s_tag[slot_line]);
            end
            pend = exp_send;
            if (exp_send) begin
                pend_line = slot_line;
                predict_operands(slot_line);
            end
            smp_read  = exp_read;
            smp_issue = exp_issue;
            smp_claim = exp_claim;
            done      = q_line >= n_lines && slot_line < 0 && !pend;
            @(posedge clk);
            #2;
        end
        $display("TESTS PASSED");
        $finish;
    end

    // 40 cycles per instruction is far beyond the longest stall
    initial begin
        wait (n_lines > 0);
        repeat (RESET_CYCLES + CYCLES_PER_LINE * n_lines) @(posedge clk);
        $display("TESTS FAILED");
        $fatal(1, "timeout, the issue stage stopped making progress");
    end

endmodule

/* vlog.f */
+incdir+.
issue_pkg.sv
instr_decoder.sv
issue_slot.sv
dispatch_unit.sv
issue_stage.sv
issue_assert.sv
tb_issue_stage.sv

/* Makefile */
TOP = tb_issue_stage

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

# a $fatal or a failed assertion gives a nonzero exit status
sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

/* issue_stimulus.txt */
# instr pc full notag hold tag unit op ksrc vk off   (all hex)
# full: bit0 alu bit1 cmp bit2 lsb, unit: 0 none 1 alu 2 cmp 3 lsb, ksrc 1: vk from rs2
00510093 00000100 0 0 0 1 1 0 0 00000005 00000000
fff0c193 00000104 0 0 0 2 1 4 0 ffffffff 00000000
00308233 00000108 0 0 0 3 1 0 1 00000000 00000000
402202b3 0000010c 0 1 2 4 1 8 1 00000000 00000000
00329313 00000110 0 0 0 5 1 1 0 00000003 00000000
12345397 00000114 1 0 3 6 1 0 0 12345000 00000000
ff80a403 00000118 0 0 0 7 3 2 0 00000000 fffffff8
00412623 0000011c 4 0 2 1 3 2 1 00000000 0000000c
fe3088e3 00000120 2 0 2 2 2 0 1 00000000 00000000
00021463 00000124 0 1 1 3 2 1 1 00000000 00000000
00108013 00000128 0 0 0 4 0 0 0 00000000 00000000
0020a4b3 0000012c 0 0 0 4 0 0 0 00000000 00000000
00225513 00000130 0 0 0 4 0 0 0 00000000 00000000
007475b3 00000134 4 0 2 4 1 7 1 00000000 00000000
0055e633 00000138 0 0 0 5 1 6 1 00000000 00000000
fec30fa3 0000013c 0 0 0 6 3 0 1 00000000 ffffffff
00464683 00000140 0 1 1 7 3 4 0 00000000 00000004
7ff68713 00000144 0 0 0 1 1 0 0 000007ff 00000000
